// ==== hdl/lsu_defines.svh ====
/*
 * Sizing for the load/store unit. Only a 64-bit data path is supported.
 * The memory index uses address bits 10..3, so addresses wrap every 2 KiB.
 */

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// --------------------------------------------------
// Data path and memory geometry
// --------------------------------------------------

// Data and address width.
`define LSU_XLEN 64

`define LSU_MEM_WORDS 256 // Depth in doublewords.
`define LSU_MEM_IDX_W 8   // Must be log2 of the depth.

`endif

// ==== hdl/lsu_pkg.sv ====
/*
 * Types shared by the load/store unit stages.
 * Store funct3 uses only B, H, W and D. Any other store code is flagged.
 */

`default_nettype none

`include "lsu_defines.svh"

package lsu_pkg;

    // --------------------------------------------------
    // funct3 encodings
    // --------------------------------------------------
    typedef enum logic [2:0] {
        F3_B  = 3'b000,
        F3_H  = 3'b001,
        F3_W  = 3'b010,
        F3_D  = 3'b011,
        F3_BU = 3'b100, // Loads only.
        F3_HU = 3'b101,
        F3_WU = 3'b110
    } funct3_e;

    // Command as it enters the unit.
    typedef struct packed {
        logic                  is_store;
        funct3_e               funct3;
        logic [`LSU_XLEN-1:0]  base;
        logic signed [11:0]    imm;
        logic [`LSU_XLEN-1:0]  wdata;
        logic [7:0]            tag;   // Echoed in the response.
    } lsu_cmd_t;

    // Decoded request from the AGU to the memory stage.
    typedef struct packed {
        logic                      is_store;
        funct3_e                   funct3;
        logic [`LSU_MEM_IDX_W-1:0] idx;
        logic [2:0]                offset;
        logic [7:0]                be;     // Zero for loads and errored stores.
        logic [`LSU_XLEN-1:0]      wdata;  // Already shifted into its lanes.
        logic                      err;
        logic [7:0]                tag;
    } mem_req_t;

    typedef struct packed {
        logic [7:0]           tag;
        logic                 err;
        logic [`LSU_XLEN-1:0] rdata;
    } lsu_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/lsu_pipe_reg.sv ====
/*
 * One-entry valid/ready register stage, payload type set by T.
 * Ready stays high while the stage is empty or being drained, so no bubbles.
 */

`timescale 1ns/1ps
`default_nettype none

module lsu_pipe_reg #(
    parameter type T = logic
) (
    input  logic i_clk,
    input  logic i_reset,

    // Upstream side.
    input  logic i_valid,
    output logic o_ready,
    input  T     i_data,

    // Downstream side.
    output logic o_valid,
    input  logic i_ready,
    output T     o_data
);

    logic r_valid;
    T     r_data;
    logic s_load;

    assign o_ready = ~r_valid | i_ready;
    assign s_load  = i_valid & o_ready;

    // Valid follows the input whenever the slot is free or draining.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_valid <= 1'b0;
        end else if (o_ready) begin
            r_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (s_load) begin
            r_data <= i_data;
        end
    end

    assign o_valid = r_valid;
    assign o_data  = r_data;

endmodule

`default_nettype wire

// ==== hdl/lsu_agu.sv ====
/*
 * Address generation and access check, purely combinational.
 * Misaligned or illegal accesses set err and get no byte enables.
 */

`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_agu (
    input  lsu_pkg::lsu_cmd_t i_cmd,
    output lsu_pkg::mem_req_t o_req
);

    import lsu_pkg::*;

    logic [`LSU_XLEN-1:0] s_addr;
    logic [2:0]           s_offset;
    logic [7:0]           s_size_mask;
    logic                 s_misaligned;
    logic                 s_illegal;
    logic                 s_err;

    // --------------------------------------------------
    // Effective address
    // --------------------------------------------------
    assign s_addr   = i_cmd.base + {{(`LSU_XLEN-12){i_cmd.imm[11]}}, i_cmd.imm};
    assign s_offset = s_addr[2:0];

    // Access size comes from the low two funct3 bits for every legal code.
    always_comb begin
        case (i_cmd.funct3[1:0])
            2'b00: begin
                s_size_mask  = 8'h01;
                s_misaligned = 1'b0;
            end
            2'b01: begin
                s_size_mask  = 8'h03;
                s_misaligned = s_addr[0];
            end
            2'b10: begin
                s_size_mask  = 8'h0F;
                s_misaligned = |s_addr[1:0];
            end
            default: begin
                s_size_mask  = 8'hFF;
                s_misaligned = |s_addr[2:0];
            end
        endcase
    end

    // Stores have no unsigned forms, loads have no code 7.
    assign s_illegal = i_cmd.is_store ? (i_cmd.funct3 > F3_D)
                                      : (i_cmd.funct3 == 3'b111);
    assign s_err     = s_misaligned | s_illegal;

    // --------------------------------------------------
    // Request
    // --------------------------------------------------
    always_comb begin
        o_req.is_store = i_cmd.is_store;
        o_req.funct3   = i_cmd.funct3;
        o_req.idx      = s_addr[`LSU_MEM_IDX_W+2:3]; // Wraps every 2 KiB.
        o_req.offset   = s_offset;
        o_req.wdata    = i_cmd.wdata << {s_offset, 3'b000};
        o_req.err      = s_err;
        o_req.tag      = i_cmd.tag;

        // Enables only for a legal store.
        if (i_cmd.is_store && !s_err) begin
            o_req.be = s_size_mask << s_offset;
        end else begin
            o_req.be = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lsu_mem_stage.sv ====
/*
 * Data memory stage. Writes and reads take place only in the accept cycle.
 * The array has no reset, so unwritten doublewords read as unknown.
 */

`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_mem_stage (
    input  logic                 i_clk,
    input  logic                 i_reset,

    // Request from the AGU register.
    input  logic                 i_req_valid,
    output logic                 o_req_ready,
    input  lsu_pkg::mem_req_t    i_req,

    // Registered output toward load_mux and the response.
    output logic                 o_out_valid,
    input  logic                 i_out_ready,
    output logic [7:0]           o_tag,
    output logic                 o_err,
    output lsu_pkg::funct3_e     o_funct3,
    output logic [2:0]           o_offset,
    output logic [`LSU_XLEN-1:0] o_rdata
);

    import lsu_pkg::*;

    logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];

    logic                 r_valid;
    logic [7:0]           r_tag;
    logic                 r_err;
    funct3_e              r_funct3;
    logic [2:0]           r_offset;
    logic [`LSU_XLEN-1:0] r_rdata;
    logic                 s_accept;

    assign o_req_ready = ~r_valid | i_out_ready;
    assign s_accept    = i_req_valid & o_req_ready;

    // --------------------------------------------------
    // Memory array
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (s_accept) begin
            for (int b = 0; b < 8; b++) begin
                if (i_req.be[b]) begin
                    mem[i_req.idx][b*8 +: 8] <= i_req.wdata[b*8 +: 8];
                end
            end
        end
    end

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            r_valid <= 1'b0;
        end else if (o_req_ready) begin
            r_valid <= i_req_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (s_accept) begin
            r_tag    <= i_req.tag;
            r_err    <= i_req.err;
            r_funct3 <= i_req.funct3;
            r_offset <= i_req.offset;
            // Stores and errored loads return zero.
            r_rdata  <= (i_req.is_store | i_req.err) ? '0 : mem[i_req.idx];
        end
    end

    assign o_out_valid = r_valid;
    assign o_tag       = r_tag;
    assign o_err       = r_err;
    assign o_funct3    = r_funct3;
    assign o_offset    = r_offset;
    assign o_rdata     = r_rdata;

endmodule

`default_nettype wire

// ==== hdl/load_mux.sv ====
/*
 * Load data alignment and extension. Only DATA_WIDTH = 64 is supported.
 * An unknown funct3 (7) yields zero.
 */

`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module load_mux #(
    parameter DATA_WIDTH = `LSU_XLEN
) (
    input  logic [2:0]            i_func3,
    input  logic [DATA_WIDTH-1:0] i_data,
    input  logic [2:0]            i_addr_offset,
    output logic [DATA_WIDTH-1:0] o_data
);

    logic [7:0]  s_byte;
    logic [15:0] s_half;
    logic [31:0] s_word;

    // Lane select by offset. Half and word ignore the low offset bits.
    assign s_byte = i_data[i_addr_offset*8 +: 8];
    assign s_half = i_data[i_addr_offset[2:1]*16 +: 16];
    assign s_word = i_addr_offset[2] ? i_data[63:32] : i_data[31:0];

    always_comb begin
        case (i_func3)
            3'b000:  o_data = {{(DATA_WIDTH-8){s_byte[7]}}, s_byte};    // LB.
            3'b001:  o_data = {{(DATA_WIDTH-16){s_half[15]}}, s_half};  // LH.
            3'b010:  o_data = {{(DATA_WIDTH-32){s_word[31]}}, s_word};  // LW.
            3'b011:  o_data = i_data;                                   // LD.
            3'b100:  o_data = {{(DATA_WIDTH-8){1'b0}}, s_byte};         // LBU.
            3'b101:  o_data = {{(DATA_WIDTH-16){1'b0}}, s_half};        // LHU.
            3'b110:  o_data = {{(DATA_WIDTH-32){1'b0}}, s_word};        // LWU.
            default: o_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/lsu_top.sv ====
/*
 * Load/store unit top. Three register stages, 3 cycles of latency.
 * One response per command, in order. Errored accesses leave memory untouched.
 */

`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module lsu_top (
    input  logic              i_clk,
    input  logic              i_reset,

    input  logic              i_cmd_valid,
    output logic              o_cmd_ready,
    input  lsu_pkg::lsu_cmd_t i_cmd,

    output logic              o_rsp_valid,
    input  logic              i_rsp_ready,
    output lsu_pkg::lsu_rsp_t o_rsp
);

    import lsu_pkg::*;

    // --------------------------------------------------
    // Stage wiring
    // --------------------------------------------------
    logic                 s_cmd_valid;
    logic                 s_cmd_ready;
    lsu_cmd_t             s_cmd;
    mem_req_t             s_req;
    logic                 s_req_q_valid;
    logic                 s_req_q_ready;
    mem_req_t             s_req_q;
    logic [7:0]           s_tag;
    logic                 s_err;
    funct3_e              s_funct3;
    logic [2:0]           s_offset;
    logic [`LSU_XLEN-1:0] s_raw_data;
    logic [`LSU_XLEN-1:0] s_load_data;

    lsu_pipe_reg #(.T(lsu_cmd_t)) i_cmd_reg (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_valid (i_cmd_valid),
        .o_ready (o_cmd_ready),
        .i_data  (i_cmd),
        .o_valid (s_cmd_valid),
        .i_ready (s_cmd_ready),
        .o_data  (s_cmd)
    );

    lsu_agu i_agu (
        .i_cmd (s_cmd),
        .o_req (s_req)
    );

    // AGU passes valid and ready straight through.
    lsu_pipe_reg #(.T(mem_req_t)) i_req_reg (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_valid (s_cmd_valid),
        .o_ready (s_cmd_ready),
        .i_data  (s_req),
        .o_valid (s_req_q_valid),
        .i_ready (s_req_q_ready),
        .o_data  (s_req_q)
    );

    lsu_mem_stage i_mem_stage (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_req_valid (s_req_q_valid),
        .o_req_ready (s_req_q_ready),
        .i_req       (s_req_q),
        .o_out_valid (o_rsp_valid),
        .i_out_ready (i_rsp_ready),
        .o_tag       (s_tag),
        .o_err       (s_err),
        .o_funct3    (s_funct3),
        .o_offset    (s_offset),
        .o_rdata     (s_raw_data)
    );

    load_mux #(.DATA_WIDTH(`LSU_XLEN)) i_load_mux (
        .i_func3       (s_funct3),
        .i_data        (s_raw_data),
        .i_addr_offset (s_offset),
        .o_data        (s_load_data)
    );

    // Zero raw data for stores and errors also zeroes the extended result.
    assign o_rsp = '{tag: s_tag, err: s_err, rdata: s_load_data};

endmodule

`default_nettype wire

// ==== tests/tb_lsu_top.sv ====
/*
 * Self-checking testbench for the load/store unit top level.
 * Random addresses stay within the first 32 doublewords, modulo the 2 KiB wrap.
 */

`timescale 1ns/1ps
`default_nettype none

`include "lsu_defines.svh"

module tb_lsu_top;

    import lsu_pkg::*;

    localparam int N_CMDS          = 598;
    localparam int WATCHDOG_CYCLES = N_CMDS * 8 + 200;

    logic     i_clk;
    logic     i_reset;
    logic     i_cmd_valid;
    logic     o_cmd_ready;
    lsu_cmd_t i_cmd;
    logic     o_rsp_valid;
    logic     i_rsp_ready;
    lsu_rsp_t o_rsp;

    logic [`LSU_XLEN-1:0] mem_model [`LSU_MEM_WORDS];
    lsu_rsp_t             exp_q [$];
    int                   sent_q [$]; // Send cycle, or -1 when latency is not checked.
    int                   cycle     = 0;
    int                   errors    = 0;
    int                   checks    = 0;
    logic [7:0]           next_tag  = 8'h00;
    bit                   bp_en     = 1'b0;
    bit                   lat_check = 1'b0;

    lsu_top i_lsu_top (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_cmd_valid (i_cmd_valid),
        .o_cmd_ready (o_cmd_ready),
        .i_cmd       (i_cmd),
        .o_rsp_valid (o_rsp_valid),
        .i_rsp_ready (i_rsp_ready),
        .o_rsp       (o_rsp)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // --------------------------------------------------
    // Expected response and memory model
    // --------------------------------------------------
    function automatic lsu_rsp_t ref_lsu(input lsu_cmd_t c);
        logic [63:0] addr;
        logic [63:0] dw;
        logic [63:0] lane;
        logic [2:0]  off;
        logic [7:0]  idx;
        int          nbytes;
        logic        bad;
        lsu_rsp_t    r;
        addr = c.base + {{52{c.imm[11]}}, c.imm};
        off  = addr[2:0];
        idx  = addr[10:3]; // 2 KiB wrap.
        case (c.funct3)
            F3_B, F3_BU: nbytes = 1;
            F3_H, F3_HU: nbytes = 2;
            F3_W, F3_WU: nbytes = 4;
            default:     nbytes = 8;
        endcase
        bad = (off % nbytes) != 0;
        if (c.is_store) begin
            bad = bad | (c.funct3 > 3'd3);
        end else begin
            bad = bad | (c.funct3 == 3'd7);
        end
        r.tag   = c.tag;
        r.err   = bad;
        r.rdata = '0;
        dw      = mem_model[idx];
        lane    = dw >> (off * 8);
        if (c.is_store && !bad) begin
            for (int i = 0; i < nbytes; i++) begin
                dw[(off + i) * 8 +: 8] = c.wdata[i * 8 +: 8];
            end
            mem_model[idx] = dw;
        end else if (!c.is_store && !bad) begin
            case (c.funct3)
                F3_B:    r.rdata = {{56{lane[7]}}, lane[7:0]};
                F3_H:    r.rdata = {{48{lane[15]}}, lane[15:0]};
                F3_W:    r.rdata = {{32{lane[31]}}, lane[31:0]};
                F3_BU:   r.rdata = {56'b0, lane[7:0]};
                F3_HU:   r.rdata = {48'b0, lane[15:0]};
                F3_WU:   r.rdata = {32'b0, lane[31:0]};
                default: r.rdata = dw;
            endcase
        end
        return r;
    endfunction

    // Random base, high bits and immediate that still land on doubleword dw.
    function automatic lsu_cmd_t make_cmd(input logic is_store, input logic [2:0] f3,
                                          input logic aligned, input int dw);
        lsu_cmd_t    c;
        int          nbytes;
        int          off;
        logic [63:0] target;
        logic [63:0] hi;
        nbytes = 1 << f3[1:0];
        if (aligned || nbytes == 1) begin
            off = ($urandom % (8 / nbytes)) * nbytes;
        end else begin
            off = $urandom % 8;
            while (off % nbytes == 0) off = $urandom % 8;
        end
        target     = dw * 8 + off;
        hi         = {$urandom, $urandom};
        hi[10:0]   = '0;
        c.is_store = is_store;
        c.funct3   = funct3_e'(f3);
        c.imm      = $urandom_range(4095, 0);
        c.base     = hi + target - {{52{c.imm[11]}}, c.imm};
        c.wdata    = {$urandom, $urandom};
        c.tag      = '0;
        return c;
    endfunction

    // --------------------------------------------------
    // Driving tasks
    // --------------------------------------------------
    task automatic send_cmd(input lsu_cmd_t c);
        c.tag       = next_tag;
        next_tag    = next_tag + 8'd1;
        i_cmd       = c;
        i_cmd_valid = 1'b1;
        @(posedge i_clk);
        while (!o_cmd_ready) @(posedge i_clk);
        #1;
    endtask

    task automatic idle(input int n);
        i_cmd_valid = 1'b0;
        repeat (n) @(posedge i_clk);
        #1;
    endtask

    task automatic drain();
        i_cmd_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge i_clk);
        @(posedge i_clk);
        #1;
    endtask

    // Output ready is low during reset, then about 30% low when enabled.
    initial begin
        i_rsp_ready = 1'b0;
        wait (i_reset === 1'b0);
        i_rsp_ready = 1'b1;
        forever begin
            @(posedge i_clk);
            #1;
            i_rsp_ready = bp_en ? (($urandom % 100) >= 30) : 1'b1;
        end
    end

    // --------------------------------------------------
    // Monitor and checker
    // --------------------------------------------------
    task automatic check_response();
        lsu_rsp_t exp;
        int       sent;
        assert (exp_q.size() != 0) else begin
            $display("Response with tag 0x%0h arrived with no command outstanding.", o_rsp.tag);
            errors = errors + 1;
        end
        if (exp_q.size() != 0) begin
            exp    = exp_q.pop_front();
            sent   = sent_q.pop_front();
            checks = checks + 1;
            assert (o_rsp.tag === exp.tag) else begin
                $display("ERROR o_rsp.tag: expected 0x%0h, got 0x%0h", exp.tag, o_rsp.tag);
                errors = errors + 1;
            end
            assert (o_rsp.err === exp.err) else begin
                $display("ERROR o_rsp.err (tag 0x%0h): expected 0x%0h, got 0x%0h",
                         exp.tag, exp.err, o_rsp.err);
                errors = errors + 1;
            end
            assert (o_rsp.rdata === exp.rdata) else begin
                $display("ERROR o_rsp.rdata (tag 0x%0h): expected 0x%0h, got 0x%0h",
                         exp.tag, exp.rdata, o_rsp.rdata);
                errors = errors + 1;
            end
            if (sent >= 0) begin
                assert (cycle - sent == 3) else begin
                    $display("ERROR latency (tag 0x%0h): expected 0x3, got 0x%0h",
                             exp.tag, cycle - sent);
                    errors = errors + 1;
                end
            end
        end
    endtask

    always @(posedge i_clk) begin
        cycle = cycle + 1;
        if (i_reset && cycle >= 2) begin // First edge still shows unreset state.
            assert (o_rsp_valid === 1'b0) else begin
                $display("ERROR o_rsp_valid in reset: expected 0x0, got 0x%0h", o_rsp_valid);
                errors = errors + 1;
            end
            assert (o_cmd_ready === 1'b1) else begin
                $display("ERROR o_cmd_ready in reset: expected 0x1, got 0x%0h", o_cmd_ready);
                errors = errors + 1;
            end
        end
        if (!i_reset && o_rsp_valid && i_rsp_ready) check_response();
        if (!i_reset && i_cmd_valid && o_cmd_ready) begin
            exp_q.push_back(ref_lsu(i_cmd));
            sent_q.push_back(lat_check ? cycle : -1);
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        logic       st;
        logic [2:0] f3;
        void'($urandom(65));
        i_reset     = 1'b1;
        i_cmd_valid = 1'b0;
        i_cmd       = '0;
        repeat (10) @(posedge i_clk);
        #1;
        i_reset = 1'b0;

        for (int i = 0; i < 32; i++) send_cmd(make_cmd(1'b1, 3'd3, 1'b1, i));
        for (int i = 0; i < 32; i++) send_cmd(make_cmd(1'b0, 3'd3, 1'b1, i));

        // All seven load codes, plus code 7.
        for (int i = 0; i < 120; i++) begin
            send_cmd(make_cmd(1'b0, $urandom % 8, 1'b1, $urandom % 32));
        end

        // Partial stores merge into existing doublewords.
        for (int i = 0; i < 80; i++) begin
            send_cmd(make_cmd(1'b1, $urandom % 3, 1'b1, $urandom % 32));
        end
        for (int i = 0; i < 32; i++) send_cmd(make_cmd(1'b0, 3'd3, 1'b1, i));

        // Misaligned accesses and illegal store codes.
        for (int i = 0; i < 60; i++) begin
            st = $urandom % 2;
            if ($urandom % 2) begin
                f3 = 1 + $urandom % 3;
                if (!st && ($urandom % 2)) f3 = f3 + 3'd4;
                send_cmd(make_cmd(st, f3, 1'b0, $urandom % 32));
            end else begin
                send_cmd(make_cmd(1'b1, 4 + $urandom % 4, $urandom % 2, $urandom % 32));
            end
        end
        for (int i = 0; i < 32; i++) send_cmd(make_cmd(1'b0, 3'd3, 1'b1, i));

        // Mixed traffic with output stalls and input gaps.
        bp_en = 1'b1;
        for (int i = 0; i < 150; i++) begin
            send_cmd(make_cmd($urandom % 2, $urandom % 8, ($urandom % 4) != 0, $urandom % 32));
            if (($urandom % 100) < 30) idle(1 + $urandom % 3);
        end
        bp_en = 1'b0;
        drain();

        // Continuous stream, fixed latency.
        lat_check = 1'b1;
        for (int i = 0; i < 60; i++) begin
            send_cmd(make_cmd($urandom % 2, $urandom % 4, 1'b1, $urandom % 32));
        end
        lat_check = 1'b0;
        drain();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("Timeout: the run did not finish within %0d cycles.", WATCHDOG_CYCLES);
        if (exp_q.size() != 0) begin
            $display("%0d responses were still outstanding.", exp_q.size());
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_pipe_reg.sv
hdl/lsu_agu.sv
hdl/lsu_mem_stage.sv
hdl/load_mux.sv
hdl/lsu_top.sv
tests/tb_lsu_top.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lsu_pkg.sv
      - hdl/lsu_pipe_reg.sv
      - hdl/lsu_agu.sv
      - hdl/lsu_mem_stage.sv
      - hdl/load_mux.sv
      - hdl/lsu_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_lsu_top.sv
